/* dv/cmd_engine_assert.sv */
`timescale 1ns/1ps

module cmd_engine_assert (
	input logic clk,
	input logic arst_n,
	input logic msg_rd_en,
	input logic send_ring_wr_en,
	input logic send_fifo_wr_en,
	input logic cmd_start,
	input logic rsp_start
);

	logic any_strobe;

	assign any_strobe = msg_rd_en || send_ring_wr_en || send_fifo_wr_en || cmd_start || rsp_start;

	rd_en_single: assert property (@(posedge clk) disable iff (!arst_n)
		msg_rd_en |=> !msg_rd_en)
		else $error("msg_rd_en high in two cycles in a row");

	fifo_with_ring: assert property (@(posedge clk) disable iff (!arst_n)
		send_fifo_wr_en |-> send_ring_wr_en)
		else $error("send_fifo_wr_en without a ring byte in the same cycle");

	quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !any_strobe)
		else $error("strobe high while reset is asserted");

endmodule

bind cmd_engine cmd_engine_assert assert_i (
	.clk(clk),
	.arst_n(arst_n),
	.msg_rd_en(msg_rd_en),
	.send_ring_wr_en(send_ring_wr_en),
	.send_fifo_wr_en(send_fifo_wr_en),
	.cmd_start(cmd_start),
	.rsp_start(rsp_start)
);

/* dv/cmd_engine_tb.sv */
`timescale 1ns/1ps

module cmd_engine_tb import proto_pkg::*, cmd_pkg::*; ();

	localparam int clk_period = 100;
	localparam int drive_dly = 10;
	// about 40 commands of under 100 cycles each, with a wide margin
	localparam int timeout_cycles = 20000;
	localparam cmd_id_t cmd_unknown = 5'd7;  // not in the command table

	logic clk;
	logic arst_n;
	msg_byte_t msg_data;
	logic msg_ready;
	arg_t systime;
	logic msg_rd_en;
	msg_byte_t send_ring_data;
	logic send_ring_wr_en;
	rsp_len_t send_fifo_data;
	logic send_fifo_wr_en;
	gpio_t gpio;

	string test_name = "reset";
	int err_cnt = 0;
	int chk_cnt = 0;
	int cycle_cnt = 0;
	int issued = 0;
	int done_cnt = 0;
	int rsp_first = 0;
	int rx_rd = 0;
	int rx_byte_rd = 0;
	msg_byte_t rx_bytes[$];
	int rx_lens[$];
	int rx_counts[$];
	msg_byte_t exp_bytes[$];
	int exp_lens[$];
	gpio_t gpio_model = '0;
	logic shutdown_model = 1'b0;

	cmd_engine dut_i (
		.clk(clk),
		.arst_n(arst_n),
		.msg_data(msg_data),
		.msg_ready(msg_ready),
		.systime(systime),
		.msg_rd_en(msg_rd_en),
		.send_ring_data(send_ring_data),
		.send_ring_wr_en(send_ring_wr_en),
		.send_fifo_data(send_fifo_data),
		.send_fifo_wr_en(send_fifo_wr_en),
		.gpio(gpio)
	);

	initial clk = 1'b0;
	always #(clk_period / 2) clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == timeout_cycles) begin
			$display("timeout: the run did not finish within %0d cycles", timeout_cycles);
			$display("tests failed");
			$finish;
		end
	end

	// outputs are registered, so the middle of the cycle is quiet
	always @(negedge clk) begin
		if (dut_i.cmd_finish)
			done_cnt = done_cnt + 1;
		if (send_ring_wr_en)
			rx_bytes.push_back(send_ring_data);
		if (send_fifo_wr_en) begin
			rx_lens.push_back(int'(send_fifo_data));
			rx_counts.push_back(rx_bytes.size() - rsp_first);
			rsp_first = rx_bytes.size();
		end
	end

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		chk_cnt++;
		assert (exp === act)
		else begin
			err_cnt++;
			$display("error %s %s: expected %0h, actual %0h", test_name, what, exp, act);
		end
	endtask

	// smallest code whose first group still decodes to the right sign
	function automatic int vlq_size(input arg_t v);
		longint sv;
		longint lim;
		sv = longint'(signed'(v));
		for (int n = 1; n < vlq_max_bytes; n++) begin
			lim = longint'(1) << (7 * n - 2);
			if (sv >= -lim && sv < 3 * lim)
				return n;
		end
		return vlq_max_bytes;
	endfunction

	function automatic msg_byte_t vlq_byte(input arg_t v, input int n, input int i);
		longint sv;
		logic [6:0] grp;
		sv = longint'(signed'(v));
		grp = 7'(sv >>> (7 * (n - 1 - i)));
		return {i != n - 1, grp};  // continuation on all but the last
	endfunction

	task automatic send_byte(input msg_byte_t b);
		msg_data = b;
		msg_ready = 1'b1;
		do begin
			@(posedge clk);
			#drive_dly;
		end while (!msg_rd_en);
		msg_ready = 1'b0;
	endtask

	task automatic send_vlq(input arg_t v);
		int n;
		n = vlq_size(v);
		for (int i = 0; i < n; i++)
			send_byte(vlq_byte(v, n, i));
	endtask

	task automatic expect_response(input msg_byte_t id, input arg_t param);
		int n;
		n = vlq_size(param);
		exp_lens.push_back(1 + n);
		exp_bytes.push_back(id);
		for (int i = 0; i < n; i++)
			exp_bytes.push_back(vlq_byte(param, n, i));
	endtask

	task automatic issue_get_version();
		issued++;
		expect_response(rsp_get_version, fw_version);
		send_byte(8'(cmd_get_version));
	endtask

	task automatic issue_get_time();
		issued++;
		expect_response(rsp_get_time, systime);
		send_byte(8'(cmd_get_time));
	endtask

	task automatic issue_set_output(input arg_t chan, input arg_t value);
		issued++;
		if (!shutdown_model)
			gpio_model[chan[2:0]] = value[0];
		send_byte(8'(cmd_set_digital_out));
		send_vlq(chan);
		send_vlq(value);
	endtask

	task automatic issue_plain(input cmd_id_t id);
		issued++;
		if (id == cmd_shutdown) begin
			shutdown_model = 1'b1;
			gpio_model = '0;
		end
		send_byte(8'(id));
	endtask

	task automatic wait_idle();
		while (done_cnt < issued) begin
			@(posedge clk);
			#drive_dly;
		end
	endtask

	task automatic compare_responses();
		int len;
		check_value("response count", exp_lens.size(), rx_lens.size() - rx_rd);
		while (exp_lens.size() > 0 && rx_rd < rx_lens.size()) begin
			len = exp_lens.pop_front();
			check_value("fifo length", len, rx_lens[rx_rd]);
			check_value("ring byte count", len, rx_counts[rx_rd]);
			for (int i = 0; i < len; i++)
				check_value("ring byte", 32'(exp_bytes.pop_front()),
					32'(rx_bytes[rx_byte_rd + i]));
			rx_byte_rd += rx_counts[rx_rd];
			rx_rd++;
		end
		exp_lens.delete();
		exp_bytes.delete();
		rx_rd = rx_lens.size();
		rx_byte_rd = rx_bytes.size();
	endtask

	task automatic test_get_version();
		test_name = "get_version";
		issue_get_version();
		wait_idle();
		compare_responses();
	endtask

	task automatic test_get_time();
		arg_t times [6];
		test_name = "get_time";
		times = '{32'd50, -32'sd20, 32'd5000, -32'sd300000, 32'h7fff_ffff, 32'd0};
		foreach (times[k]) begin
			systime = times[k];
			issue_get_time();
			wait_idle();
			compare_responses();
		end
	endtask

	task automatic test_set_outputs();
		arg_t vals [8];
		test_name = "set_digital_out";
		// codes of 1, 1, 2, 3, 3, 4, 4 and 5 bytes
		vals = '{32'd1, -32'sd1, 32'd201, -32'sd5000, 32'd300001, -32'sd2000001,
			32'd100000000, 32'h8000_0001};
		for (int ch = 0; ch < ngpio; ch++) begin
			issue_set_output(32'(ch), vals[ch]);
			wait_idle();
			compare_responses();
			check_value("gpio", 32'(gpio_model), 32'(gpio));
		end
	endtask

	task automatic test_back_to_back();
		int kind;
		test_name = "back_to_back";
		systime = $urandom;
		for (int k = 0; k < 20; k++) begin
			kind = $urandom_range(0, 3);
			case (kind)
				0: issue_get_version();
				1: issue_get_time();
				2: issue_set_output(32'($urandom_range(0, ngpio - 1)), $urandom);
				default: issue_plain(cmd_unknown);
			endcase
		end
		wait_idle();
		compare_responses();
		check_value("gpio", 32'(gpio_model), 32'(gpio));
	endtask

	task automatic test_shutdown();
		test_name = "shutdown";
		issue_set_output(32'd3, 32'd1);
		wait_idle();
		check_value("gpio before shutdown", 32'(gpio_model), 32'(gpio));
		issue_plain(cmd_shutdown);
		wait_idle();
		check_value("gpio after shutdown", 32'd0, 32'(gpio));
		issue_set_output(32'd5, 32'd1);
		issue_set_output(32'd0, -32'sd1);
		wait_idle();
		check_value("gpio held low", 32'd0, 32'(gpio));
		issue_get_version();
		wait_idle();
		compare_responses();
	endtask

	initial begin
		void'($urandom(32'h4ebe_8319));
		arst_n = 1'b0;
		msg_data = '0;
		msg_ready = 1'b0;
		systime = '0;
		repeat (2) @(posedge clk);
		#drive_dly;
		arst_n = 1'b1;
		check_value("gpio after reset", 32'd0, 32'(gpio));

		test_get_version();
		test_get_time();
		test_set_outputs();
		test_back_to_back();
		test_shutdown();  // last, the latch only clears on reset

		$display("checks %0d, errors %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* rtl/arg_parser.sv */
`timescale 1ns/1ps

module arg_parser import proto_pkg::*, cmd_pkg::*; (
	input logic clk,
	input logic arst_n,
	input msg_byte_t msg_data,
	input logic msg_ready,
	output logic msg_rd_en,
	output logic cmd_start,
	output cmd_id_t cmd,
	output unit_id_t unit,
	output logic has_response,
	input arg_idx_t arg_rd_idx,
	output arg_t arg_rd_data,
	input logic cmd_finish
);

	parse_state_t state;
	arg_t args [max_args];
	arg_t tmp_arg;
	arg_idx_t curr_arg;
	arg_idx_t nargs;
	cmd_entry_t entry;
	logic take;

	assign take = msg_ready && !msg_rd_en;  // at most every other cycle
	assign entry = cmd_table(msg_data[4:0]);
	assign arg_rd_data = args[arg_rd_idx];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= parse_idle;
			msg_rd_en <= 1'b0;
			cmd_start <= 1'b0;
			cmd <= '0;
			unit <= unit_system;
			has_response <= 1'b0;
			curr_arg <= '0;
			nargs <= '0;
			tmp_arg <= '0;
		end else begin
			msg_rd_en <= 1'b0;
			cmd_start <= 1'b0;
			case (state)
				parse_idle: begin
					if (take) begin
						msg_rd_en <= 1'b1;
						cmd <= msg_data[4:0];
						{unit, nargs, has_response} <= entry;
						curr_arg <= '0;
						if (entry[3:1] == '0) begin
							cmd_start <= 1'b1;
							state <= parse_busy;
						end else begin
							state <= parse_arg_start;
						end
					end
				end
				parse_arg_start: begin
					if (take) begin
						msg_rd_en <= 1'b1;
						// 11 in bits 6:5 of the first byte means negative
						tmp_arg <= {{25{msg_data[6] & msg_data[5]}}, msg_data[6:0]};
						state <= msg_data[7] ? parse_arg_cont : parse_arg_end;
					end
				end
				parse_arg_cont: begin
					if (take) begin
						msg_rd_en <= 1'b1;
						tmp_arg <= {tmp_arg[24:0], msg_data[6:0]};
						if (!msg_data[7])
							state <= parse_arg_end;
					end
				end
				parse_arg_end: begin
					curr_arg <= curr_arg + 1'b1;
					if (curr_arg + 1'b1 == nargs) begin
						cmd_start <= 1'b1;
						state <= parse_busy;
					end else begin
						state <= parse_arg_start;
					end
				end
				parse_busy: begin
					if (cmd_finish)
						state <= parse_idle;
				end
				default: state <= parse_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == parse_arg_end)
			args[curr_arg] <= tmp_arg;
	end

endmodule

/* rtl/cmd_dispatch.sv */
`timescale 1ns/1ps

module cmd_dispatch import proto_pkg::*, cmd_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic cmd_start,
	input cmd_id_t cmd,
	input unit_id_t unit,
	input logic has_response,
	output arg_idx_t arg_rd_idx,
	input arg_t arg_rd_data,
	output logic cmd_finish,
	unit_if.dispatch sys_bus,
	unit_if.dispatch dout_bus,
	output logic rsp_start,
	output msg_byte_t rsp_id,
	output param_cnt_t nparams,
	input param_idx_t param_rd_idx,
	output arg_t param_rd_data,
	input logic rsp_finish
);

	arg_t params [nparams_max];
	arg_idx_t arg_ptr;
	arg_t arg_data;
	logic cmd_ready;
	logic sel_dout;
	logic arg_advance;
	logic param_write;
	arg_t param_data;
	logic cmd_done;
	logic param_store;

	assign sel_dout = (unit == unit_digital_out);
	assign arg_rd_idx = arg_ptr;
	assign param_rd_data = params[param_rd_idx];

	assign sys_bus.cmd = cmd;
	assign sys_bus.arg_data = arg_data;
	assign sys_bus.cmd_ready = cmd_ready && !sel_dout;
	assign dout_bus.cmd = cmd;
	assign dout_bus.arg_data = arg_data;
	assign dout_bus.cmd_ready = cmd_ready && sel_dout;

	assign arg_advance = sel_dout ? dout_bus.arg_advance : sys_bus.arg_advance;
	assign param_write = sel_dout ? dout_bus.param_write : sys_bus.param_write;
	assign param_data = sel_dout ? dout_bus.param_data : sys_bus.param_data;
	assign cmd_done = sel_dout ? dout_bus.cmd_done : sys_bus.cmd_done;
	assign param_store = param_write && (nparams < nparams_max);  // extra params dropped

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cmd_ready <= 1'b0;
			rsp_start <= 1'b0;
			cmd_finish <= 1'b0;
			rsp_id <= '0;
			nparams <= '0;
			arg_ptr <= '0;
			arg_data <= '0;
		end else begin
			cmd_ready <= 1'b0;
			rsp_start <= 1'b0;
			cmd_finish <= 1'b0;
			if (cmd_start) begin
				arg_data <= arg_rd_data;  // pointer sits at 0 between commands
				arg_ptr <= arg_idx_t'(1);
				nparams <= '0;
				cmd_ready <= 1'b1;
			end
			if (arg_advance) begin
				arg_data <= arg_rd_data;
				arg_ptr <= arg_ptr + 1'b1;
			end
			if (param_store)
				nparams <= nparams + 1'b1;
			if (cmd_done) begin
				arg_ptr <= '0;
				if (has_response) begin
					rsp_start <= 1'b1;
					rsp_id <= param_data[7:0];
				end else begin
					cmd_finish <= 1'b1;
				end
			end
			if (rsp_finish)
				cmd_finish <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (param_store)
			params[param_idx_t'(nparams)] <= param_data;
	end

endmodule

/* rtl/cmd_engine.sv */
`timescale 1ns/1ps

module cmd_engine import proto_pkg::*, cmd_pkg::*; (
	input logic clk,
	input logic arst_n,
	input msg_byte_t msg_data,
	input logic msg_ready,
	input arg_t systime,
	output logic msg_rd_en,
	output msg_byte_t send_ring_data,
	output logic send_ring_wr_en,
	output rsp_len_t send_fifo_data,
	output logic send_fifo_wr_en,
	output gpio_t gpio
);

	logic cmd_start;
	cmd_id_t cmd;
	unit_id_t unit;
	logic has_response;
	arg_idx_t arg_rd_idx;
	arg_t arg_rd_data;
	logic cmd_finish;
	logic rsp_start;
	msg_byte_t rsp_id;
	param_cnt_t nparams;
	param_idx_t param_rd_idx;
	arg_t param_rd_data;
	logic rsp_finish;
	logic shutdown;

	unit_if sys_bus ();
	unit_if dout_bus ();

	arg_parser u_parser (
		.clk(clk), .arst_n(arst_n),
		.msg_data(msg_data), .msg_ready(msg_ready), .msg_rd_en(msg_rd_en),
		.cmd_start(cmd_start), .cmd(cmd), .unit(unit), .has_response(has_response),
		.arg_rd_idx(arg_rd_idx), .arg_rd_data(arg_rd_data), .cmd_finish(cmd_finish)
	);

	cmd_dispatch u_dispatch (
		.clk(clk), .arst_n(arst_n),
		.cmd_start(cmd_start), .cmd(cmd), .unit(unit), .has_response(has_response),
		.arg_rd_idx(arg_rd_idx), .arg_rd_data(arg_rd_data), .cmd_finish(cmd_finish),
		.sys_bus(sys_bus.dispatch), .dout_bus(dout_bus.dispatch),
		.rsp_start(rsp_start), .rsp_id(rsp_id), .nparams(nparams),
		.param_rd_idx(param_rd_idx), .param_rd_data(param_rd_data), .rsp_finish(rsp_finish)
	);

	rsp_encoder u_encoder (
		.clk(clk), .arst_n(arst_n),
		.rsp_start(rsp_start), .rsp_id(rsp_id), .nparams(nparams),
		.param_rd_idx(param_rd_idx), .param_rd_data(param_rd_data), .rsp_finish(rsp_finish),
		.send_ring_data(send_ring_data), .send_ring_wr_en(send_ring_wr_en),
		.send_fifo_data(send_fifo_data), .send_fifo_wr_en(send_fifo_wr_en)
	);

	system_unit u_system (
		.clk(clk), .arst_n(arst_n), .bus(sys_bus.unit),
		.systime(systime), .shutdown(shutdown)
	);

	digital_out_unit u_dout (
		.clk(clk), .arst_n(arst_n), .bus(dout_bus.unit),
		.shutdown(shutdown), .gpio(gpio)
	);

endmodule

/* rtl/cmd_pkg.sv */
package cmd_pkg;

	typedef logic [4:0] cmd_id_t;
	typedef logic [0:0] unit_id_t;

	localparam unit_id_t unit_system = 1'b0;
	localparam unit_id_t unit_digital_out = 1'b1;

	localparam int max_args = 8;
	typedef logic [2:0] arg_idx_t;
	localparam int nparams_max = 4;
	typedef logic [1:0] param_idx_t;
	typedef logic [2:0] param_cnt_t;  // 0 up to nparams_max

	localparam cmd_id_t cmd_get_version = 5'd0;
	localparam cmd_id_t cmd_get_time = 5'd2;
	localparam cmd_id_t cmd_set_digital_out = 5'd15;
	localparam cmd_id_t cmd_shutdown = 5'd19;

	localparam logic [7:0] rsp_get_version = 8'd0;
	localparam logic [7:0] rsp_get_time = 8'd1;

	// { unit, nargs, has_response }
	typedef logic [4:0] cmd_entry_t;

	function automatic cmd_entry_t cmd_table(input cmd_id_t id);
		case (id)
			cmd_get_version: return {unit_system, arg_idx_t'(0), 1'b1};
			cmd_get_time: return {unit_system, arg_idx_t'(0), 1'b1};
			cmd_set_digital_out: return {unit_digital_out, arg_idx_t'(2), 1'b0};
			default: return {unit_system, arg_idx_t'(0), 1'b0};  // shutdown and unknown ids
		endcase
	endfunction

	localparam logic [31:0] fw_version = 32'h0123_4567;

	localparam int ngpio = 8;
	typedef logic [ngpio-1:0] gpio_t;

	typedef enum logic [2:0] {
		parse_idle, parse_arg_start, parse_arg_cont, parse_arg_end, parse_busy
	} parse_state_t;

	typedef enum logic [1:0] {enc_idle, enc_param, enc_skip, enc_send} enc_state_t;

endpackage

/* rtl/digital_out_unit.sv */
`timescale 1ns/1ps

module digital_out_unit import cmd_pkg::*; (
	input logic clk,
	input logic arst_n,
	unit_if.unit bus,
	input logic shutdown,
	output gpio_t gpio
);

	logic [$clog2(ngpio)-1:0] chan;
	logic adv_wait;
	logic val_wait;

	assign bus.arg_advance = adv_wait;
	assign bus.param_write = 1'b0;
	assign bus.param_data = '0;  // no responses from this unit

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			gpio <= '0;
			chan <= '0;
			adv_wait <= 1'b0;
			val_wait <= 1'b0;
			bus.cmd_done <= 1'b0;
		end else begin
			bus.cmd_done <= 1'b0;
			adv_wait <= 1'b0;
			val_wait <= adv_wait;  // value on arg_data one cycle after the advance
			if (bus.cmd_ready) begin
				if (bus.cmd == cmd_set_digital_out) begin
					chan <= bus.arg_data[$clog2(ngpio)-1:0];
					adv_wait <= 1'b1;
				end else begin
					bus.cmd_done <= 1'b1;
				end
			end
			if (val_wait) begin
				if (!shutdown)
					gpio[chan] <= bus.arg_data[0];
				bus.cmd_done <= 1'b1;
			end
			if (shutdown)
				gpio <= '0;
		end
	end

endmodule

/* rtl/proto_pkg.sv */
package proto_pkg;

	typedef logic [7:0] msg_byte_t;   // one byte of the host stream
	typedef logic [31:0] arg_t;       // signed on the wire
	typedef logic [7:0] rsp_len_t;

	// a 32 bit value needs at most five 7 bit groups
	localparam int vlq_max_bytes = 5;
	localparam int vlq_bits = vlq_max_bytes * 7;

endpackage

/* rtl/rsp_encoder.sv */
`timescale 1ns/1ps

module rsp_encoder import proto_pkg::*, cmd_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic rsp_start,
	input msg_byte_t rsp_id,
	input param_cnt_t nparams,
	output param_idx_t param_rd_idx,
	input arg_t param_rd_data,
	output logic rsp_finish,
	output msg_byte_t send_ring_data,
	output logic send_ring_wr_en,
	output rsp_len_t send_fifo_data,
	output logic send_fifo_wr_en
);

	enc_state_t state;
	logic [vlq_bits-1:0] ext;
	logic [vlq_bits-1:0] rcv;
	logic [2:0] len;
	logic [2:0] cnt;
	param_idx_t curr_param;
	rsp_len_t rsp_len;
	logic last_param;

	// drop leading groups that only repeat the sign
	function automatic logic [2:0] vlq_len(input logic [vlq_bits-1:0] v);
		logic [vlq_bits-1:0] t;
		logic [2:0] n;
		logic stop;
		t = v;
		n = 3'(vlq_max_bytes);
		stop = 1'b0;
		for (int i = 1; i < vlq_max_bytes; i++) begin
			if (!stop && (t[vlq_bits-1 -: 9] == '1 || t[vlq_bits-1 -: 9] < 9'd3)) begin
				t = t << 7;
				n = n - 1'b1;
			end else begin
				stop = 1'b1;
			end
		end
		return n;
	endfunction

	assign ext = vlq_bits'(signed'(param_rd_data));  // sign extend to 5 groups
	assign len = vlq_len(ext);
	assign param_rd_idx = curr_param;
	assign last_param = ({1'b0, curr_param} + param_cnt_t'(1) == nparams);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= enc_idle;
			send_ring_wr_en <= 1'b0;
			send_fifo_wr_en <= 1'b0;
			rsp_finish <= 1'b0;
			send_ring_data <= '0;
			send_fifo_data <= '0;
			rcv <= '0;
			cnt <= '0;
			curr_param <= '0;
			rsp_len <= '0;
		end else begin
			send_ring_wr_en <= 1'b0;
			send_fifo_wr_en <= 1'b0;
			rsp_finish <= 1'b0;
			case (state)
				enc_idle: begin
					if (rsp_start)
						state <= enc_param;
				end
				enc_param: begin
					send_ring_data <= rsp_id;  // id goes out raw
					send_ring_wr_en <= 1'b1;
					rsp_len <= rsp_len_t'(1);
					curr_param <= '0;
					if (nparams == '0) begin
						send_fifo_data <= rsp_len_t'(1);
						send_fifo_wr_en <= 1'b1;
						rsp_finish <= 1'b1;
						state <= enc_idle;
					end else begin
						state <= enc_skip;
					end
				end
				enc_skip: begin
					rcv <= ext << (7 * (vlq_max_bytes - len));
					cnt <= len;
					state <= enc_send;
				end
				enc_send: begin
					send_ring_data <= {cnt != 3'd1, rcv[vlq_bits-1 -: 7]};
					send_ring_wr_en <= 1'b1;
					rsp_len <= rsp_len + 1'b1;
					cnt <= cnt - 1'b1;
					rcv <= rcv << 7;
					if (cnt == 3'd1) begin
						if (last_param) begin
							send_fifo_data <= rsp_len + 1'b1;
							send_fifo_wr_en <= 1'b1;
							rsp_finish <= 1'b1;
							state <= enc_idle;
						end else begin
							curr_param <= curr_param + 1'b1;
							state <= enc_skip;
						end
					end
				end
				default: state <= enc_idle;
			endcase
		end
	end

endmodule

/* rtl/system_unit.sv */
`timescale 1ns/1ps

module system_unit import proto_pkg::*, cmd_pkg::*; (
	input logic clk,
	input logic arst_n,
	unit_if.unit bus,
	input arg_t systime,
	output logic shutdown
);

	logic rsp_pending;
	msg_byte_t rsp_code;

	assign bus.arg_advance = 1'b0;  // none of these take arguments

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bus.param_data <= '0;
			bus.param_write <= 1'b0;
			bus.cmd_done <= 1'b0;
			rsp_pending <= 1'b0;
			rsp_code <= '0;
			shutdown <= 1'b0;
		end else begin
			bus.param_write <= 1'b0;
			bus.cmd_done <= 1'b0;
			if (rsp_pending) begin
				bus.param_data <= arg_t'(rsp_code);  // response id rides with cmd_done
				bus.cmd_done <= 1'b1;
				rsp_pending <= 1'b0;
			end else if (bus.cmd_ready) begin
				case (bus.cmd)
					cmd_get_version: begin
						bus.param_data <= fw_version;
						bus.param_write <= 1'b1;
						rsp_code <= rsp_get_version;
						rsp_pending <= 1'b1;
					end
					cmd_get_time: begin
						bus.param_data <= systime;
						bus.param_write <= 1'b1;
						rsp_code <= rsp_get_time;
						rsp_pending <= 1'b1;
					end
					cmd_shutdown: begin
						shutdown <= 1'b1;  // held until reset
						bus.cmd_done <= 1'b1;
					end
					default: bus.cmd_done <= 1'b1;
				endcase
			end
		end
	end

endmodule

/* rtl/unit_if.sv */
`timescale 1ns/1ps

interface unit_if import proto_pkg::*, cmd_pkg::*; ();

	cmd_id_t cmd;
	logic cmd_ready;     // one cycle, arg 0 already on arg_data
	arg_t arg_data;
	logic arg_advance;   // next arg shows up on arg_data a cycle later
	arg_t param_data;    // holds the response id in the cmd_done cycle
	logic param_write;
	logic cmd_done;

	modport dispatch (
		output cmd, cmd_ready, arg_data,
		input arg_advance, param_data, param_write, cmd_done
	);

	modport unit (
		input cmd, cmd_ready, arg_data,
		output arg_advance, param_data, param_write, cmd_done
	);

endinterface

/* run.sh */
#!/usr/bin/env bash
# compile and run the cmd_engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -f verilog.f --top-module cmd_engine_tb -Mdir "$build_dir"
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

"./$build_dir/Vcmd_engine_tb" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "all tests passed" "$log"; then
	exit 0
fi
echo "pass message not found in $log"
exit 1

/* verilog.f */
rtl/proto_pkg.sv
rtl/cmd_pkg.sv
rtl/unit_if.sv
rtl/arg_parser.sv
rtl/cmd_dispatch.sv
rtl/rsp_encoder.sv
rtl/system_unit.sv
rtl/digital_out_unit.sv
rtl/cmd_engine.sv
dv/cmd_engine_assert.sv
dv/cmd_engine_tb.sv
